/* rtl/tracker_pkg.sv */
`default_nettype none

package tracker_pkg;

  // ==========================================================
  // screen geometry and coordinate widths
  // ==========================================================

  // active area of the incoming video
  localparam int SCREEN_WIDTH = 1280;
  localparam int SCREEN_HEIGHT = 720;

  localparam int HCOUNT_BITS = 11;
  localparam int VCOUNT_BITS = 10;

  // red and blue must stay at or below this to count as player
  localparam logic [7:0] MASK_CEILING = 8'hF0;

  // overlay colours, r in the top byte
  localparam logic [23:0] CROSSHAIR_COLOR = 24'hFF0000;
  localparam logic [23:0] MASK_TINT_COLOR = 24'hFF00FF;

  // ==========================================================
  // pixel and result types
  // ==========================================================

  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // one beat of the input stream
  typedef struct packed {
    logic valid;
    logic [HCOUNT_BITS-1:0] hcount;
    logic [VCOUNT_BITS-1:0] vcount;
    rgb565_t color;
  } pixel_in_t;

  // beat after expansion, with its player bit
  typedef struct packed {
    logic valid;
    logic [HCOUNT_BITS-1:0] hcount;
    logic [VCOUNT_BITS-1:0] vcount;
    rgb888_t color;
    logic mask;
  } masked_pixel_t;

  // threshold nibbles, each used as the upper nibble of an 8 bit bound
  typedef struct packed {
    logic [3:0] green_upper;
    logic [3:0] red_lower;
    logic [3:0] blue_lower;
  } thresholds_t;

  // locked goes high with the first computed centroid
  typedef struct packed {
    logic locked;
    logic [HCOUNT_BITS-1:0] x;
    logic [VCOUNT_BITS-1:0] y;
  } centroid_t;

  typedef enum logic [1:0] {
    DISP_CAMERA = 2'b00,
    DISP_MASK = 2'b01,
    DISP_CROSSHAIR = 2'b10,
    DISP_TINT = 2'b11
  } display_mode_t;

endpackage

`default_nettype wire

/* rtl/mask_classifier.sv */
`timescale 1ns/10ps
`default_nettype none

module mask_classifier (
  input wire clk_pixel,
  input wire recent_reset,
  input wire tracker_pkg::pixel_in_t pixel_i,
  input wire tracker_pkg::thresholds_t thresholds_i,
  output tracker_pkg::masked_pixel_t masked_o
);
  import tracker_pkg::*;

  // ==========================================================
  // colour expansion
  // ==========================================================

  // low bits padded with zeros, no replication of the msbs
  rgb888_t color_wide;
  always_comb begin
    color_wide.r = {pixel_i.color.r, 3'b000};
    color_wide.g = {pixel_i.color.g, 2'b00};
    color_wide.b = {pixel_i.color.b, 3'b000};
  end

  // ==========================================================
  // green screen test
  // ==========================================================

  // nibbles become the upper half of each 8 bit bound
  logic [7:0] green_upper;
  logic [7:0] red_lower;
  logic [7:0] blue_lower;
  assign green_upper = {thresholds_i.green_upper, 4'h0};
  assign red_lower = {thresholds_i.red_lower, 4'h0};
  assign blue_lower = {thresholds_i.blue_lower, 4'h0};

  // player = little green, red and blue inside their windows
  logic is_player;
  assign is_player = (color_wide.g <= green_upper) &&
                     (color_wide.r >= red_lower) && (color_wide.r <= MASK_CEILING) &&
                     (color_wide.b >= blue_lower) && (color_wide.b <= MASK_CEILING);

  // ==========================================================
  // output register, one cycle
  // ==========================================================

  logic valid_q;
  logic [HCOUNT_BITS-1:0] hcount_q;
  logic [VCOUNT_BITS-1:0] vcount_q;
  rgb888_t color_q;
  logic mask_q;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= pixel_i.valid;
    end
  end

  // payload follows every cycle, valid tells whether it counts
  always_ff @(posedge clk_pixel) begin
    hcount_q <= pixel_i.hcount;
    vcount_q <= pixel_i.vcount;
    color_q <= color_wide;
    mask_q <= is_player;
  end

  assign masked_o = '{valid: valid_q, hcount: hcount_q, vcount: vcount_q,
                      color: color_q, mask: mask_q};

endmodule

`default_nettype wire

/* rtl/serial_divider.sv */
`timescale 1ns/10ps
`default_nettype none

module serial_divider #(
  parameter int DIVIDEND_BITS = 31,
  parameter int DIVISOR_BITS = 20,
  parameter int QUOT_BITS = 11
) (
  input wire clk_pixel,
  input wire recent_reset,
  input wire start_i,
  input wire [DIVIDEND_BITS-1:0] dividend_i,
  input wire [DIVISOR_BITS-1:0] divisor_i,
  output logic [QUOT_BITS-1:0] quotient_o,
  output logic done_o
);

  // working width holds the dividend and the fully shifted divisor
  localparam int WORK_BITS = (DIVIDEND_BITS > DIVISOR_BITS + QUOT_BITS) ?
                             DIVIDEND_BITS : DIVISOR_BITS + QUOT_BITS;
  localparam int CNT_BITS = $clog2(QUOT_BITS + 1);

  logic [WORK_BITS-1:0] rem_q;
  logic [WORK_BITS-1:0] div_q;
  logic [QUOT_BITS-1:0] quot_q;
  logic [CNT_BITS-1:0] cnt_q;
  logic busy_q;
  logic done_q;

  // ==========================================================
  // one restoring step per cycle
  // ==========================================================

  // the start cycle already resolves the msb, so a full result
  // takes exactly QUOT_BITS edges
  logic [WORK_BITS-1:0] rem_in;
  logic [WORK_BITS-1:0] div_in;
  assign rem_in = start_i ? WORK_BITS'(dividend_i) : rem_q;
  assign div_in = start_i ? (WORK_BITS'(divisor_i) << (QUOT_BITS - 1)) : div_q;

  // trial subtraction, borrow in the top bit
  logic [WORK_BITS:0] trial;
  logic q_bit;
  assign trial = {1'b0, rem_in} - {1'b0, div_in};
  assign q_bit = ~trial[WORK_BITS];

  // steps still to do after this one
  logic step_en;
  logic [CNT_BITS-1:0] cnt_next;
  assign step_en = start_i || busy_q;
  assign cnt_next = start_i ? CNT_BITS'(QUOT_BITS - 1) : cnt_q - 1'b1;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy_q <= 1'b0;
      cnt_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= step_en && (cnt_next == '0);
      if (step_en) begin
        cnt_q <= cnt_next;
        busy_q <= (cnt_next != '0);
      end
    end
  end

  // datapath, restored when the trial underflows
  always_ff @(posedge clk_pixel) begin
    if (step_en) begin
      rem_q <= q_bit ? trial[WORK_BITS-1:0] : rem_in;
      div_q <= div_in >> 1;
      if (start_i) begin
        quot_q <= QUOT_BITS'(q_bit);
      end else begin
        quot_q <= (quot_q << 1) | QUOT_BITS'(q_bit);
      end
    end
  end

  assign quotient_o = quot_q;
  assign done_o = done_q;

endmodule

`default_nettype wire

/* rtl/centroid_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module centroid_tracker #(
  parameter int SCREEN_WIDTH = tracker_pkg::SCREEN_WIDTH,
  parameter int SCREEN_HEIGHT = tracker_pkg::SCREEN_HEIGHT
) (
  input wire clk_pixel,
  input wire recent_reset,
  input wire tracker_pkg::masked_pixel_t masked_i,
  input wire frame_end_i,
  input wire track_enable_i,
  output tracker_pkg::centroid_t centroid_o,
  output logic centroid_valid_o
);
  import tracker_pkg::*;

  // count holds a full screen of player pixels
  localparam int COUNT_BITS = $clog2(SCREEN_WIDTH * SCREEN_HEIGHT + 1);
  // both dividers share one quotient width so they finish together
  localparam int QUOT_BITS = ($clog2(SCREEN_WIDTH) > $clog2(SCREEN_HEIGHT)) ?
                             $clog2(SCREEN_WIDTH) : $clog2(SCREEN_HEIGHT);
  localparam int SUM_BITS = COUNT_BITS + QUOT_BITS;

  // ==========================================================
  // per frame accumulation
  // ==========================================================

  logic hit;
  logic [SUM_BITS-1:0] x_add;
  logic [SUM_BITS-1:0] y_add;
  assign hit = masked_i.valid && masked_i.mask && track_enable_i;
  assign x_add = hit ? SUM_BITS'(masked_i.hcount) : '0;
  assign y_add = hit ? SUM_BITS'(masked_i.vcount) : '0;

  logic [SUM_BITS-1:0] sum_x_q;
  logic [SUM_BITS-1:0] sum_y_q;
  logic [COUNT_BITS-1:0] count_q;

  // on frame end the new frame starts with the beat of that cycle
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      sum_x_q <= '0;
      sum_y_q <= '0;
      count_q <= '0;
    end else if (frame_end_i) begin
      sum_x_q <= x_add;
      sum_y_q <= y_add;
      count_q <= COUNT_BITS'(hit);
    end else begin
      sum_x_q <= sum_x_q + x_add;
      sum_y_q <= sum_y_q + y_add;
      count_q <= count_q + COUNT_BITS'(hit);
    end
  end

  // ==========================================================
  // frame end snapshot and divider launch
  // ==========================================================

  // empty frames and frame ends during a division are dropped
  logic accept;
  logic busy_q;
  logic start_q;
  logic div_done;
  assign accept = frame_end_i && !busy_q && (count_q != '0);

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      busy_q <= 1'b0;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (div_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  // operands stay put for the whole division
  logic [SUM_BITS-1:0] snap_x_q;
  logic [SUM_BITS-1:0] snap_y_q;
  logic [COUNT_BITS-1:0] snap_count_q;
  always_ff @(posedge clk_pixel) begin
    if (accept) begin
      snap_x_q <= sum_x_q;
      snap_y_q <= sum_y_q;
      snap_count_q <= count_q;
    end
  end

  logic [QUOT_BITS-1:0] quot_x;
  logic [QUOT_BITS-1:0] quot_y;
  logic x_done;
  logic y_done;

  serial_divider #(
    .DIVIDEND_BITS(SUM_BITS),
    .DIVISOR_BITS(COUNT_BITS),
    .QUOT_BITS(QUOT_BITS)
  ) x_divider (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(start_q),
    .dividend_i(snap_x_q),
    .divisor_i(snap_count_q),
    .quotient_o(quot_x),
    .done_o(x_done)
  );

  serial_divider #(
    .DIVIDEND_BITS(SUM_BITS),
    .DIVISOR_BITS(COUNT_BITS),
    .QUOT_BITS(QUOT_BITS)
  ) y_divider (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .start_i(start_q),
    .dividend_i(snap_y_q),
    .divisor_i(snap_count_q),
    .quotient_o(quot_y),
    .done_o(y_done)
  );

  assign div_done = x_done && y_done;

  // ==========================================================
  // held result
  // ==========================================================

  centroid_t centroid_q;
  logic valid_q;
  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      centroid_q <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= div_done;
      if (div_done) begin
        centroid_q <= '{locked: 1'b1, x: HCOUNT_BITS'(quot_x), y: VCOUNT_BITS'(quot_y)};
      end
    end
  end

  assign centroid_o = centroid_q;
  assign centroid_valid_o = valid_q;

endmodule

`default_nettype wire

/* rtl/overlay_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module overlay_mux (
  input wire clk_pixel,
  input wire recent_reset,
  input wire tracker_pkg::masked_pixel_t masked_i,
  input wire tracker_pkg::centroid_t centroid_i,
  input wire tracker_pkg::display_mode_t mode_i,
  output tracker_pkg::rgb888_t pixel_o,
  output logic pixel_valid_o
);
  import tracker_pkg::*;

  // ==========================================================
  // colour select
  // ==========================================================

  // crosshair only once a centroid exists, otherwise row 0 and
  // column 0 would light up after reset
  logic on_crosshair;
  assign on_crosshair = centroid_i.locked &&
                        ((masked_i.hcount == centroid_i.x) ||
                         (masked_i.vcount == centroid_i.y));

  rgb888_t color_sel;
  always_comb begin
    unique case (mode_i)
      DISP_CAMERA: begin
        color_sel = masked_i.color;
      end
      DISP_MASK: begin
        // white where player, black elsewhere
        color_sel = masked_i.mask ? 24'hFFFFFF : 24'h000000;
      end
      DISP_CROSSHAIR: begin
        color_sel = on_crosshair ? CROSSHAIR_COLOR : masked_i.color;
      end
      DISP_TINT: begin
        color_sel = masked_i.mask ? MASK_TINT_COLOR : masked_i.color;
      end
      default: begin
        color_sel = masked_i.color;
      end
    endcase
  end

  // ==========================================================
  // output register
  // ==========================================================

  logic valid_q;
  rgb888_t color_q;

  always_ff @(posedge clk_pixel) begin
    if (recent_reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= masked_i.valid;
    end
  end

  // colour is sampled every cycle, valid qualifies it
  always_ff @(posedge clk_pixel) begin
    color_q <= color_sel;
  end

  assign pixel_o = color_q;
  assign pixel_valid_o = valid_q;

endmodule

`default_nettype wire

/* rtl/chroma_tracker.sv */
`timescale 1ns/10ps
`default_nettype none

module chroma_tracker #(
  parameter int SCREEN_WIDTH = tracker_pkg::SCREEN_WIDTH,
  parameter int SCREEN_HEIGHT = tracker_pkg::SCREEN_HEIGHT
) (
  input wire clk_pixel,
  input wire recent_reset,
  // pixel stream, valid is a one beat strobe
  input wire tracker_pkg::pixel_in_t pixel_i,
  input wire frame_end_i,
  // static configuration
  input wire tracker_pkg::thresholds_t thresholds_i,
  input wire tracker_pkg::display_mode_t mode_i,
  input wire track_enable_i,
  // drawn pixel, 2 cycles behind pixel_i
  output tracker_pkg::rgb888_t pixel_o,
  output logic pixel_valid_o,
  // last centroid and its update strobe
  output tracker_pkg::centroid_t centroid_o,
  output logic centroid_valid_o
);
  import tracker_pkg::*;

  // ==========================================================
  // classifier, shared by tracking and drawing
  // ==========================================================

  masked_pixel_t masked_pixel;
  centroid_t centroid;

  mask_classifier classifier (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_i(pixel_i),
    .thresholds_i(thresholds_i),
    .masked_o(masked_pixel)
  );

  // ==========================================================
  // center of mass
  // ==========================================================

  centroid_tracker #(
    .SCREEN_WIDTH(SCREEN_WIDTH),
    .SCREEN_HEIGHT(SCREEN_HEIGHT)
  ) tracker (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .masked_i(masked_pixel),
    .frame_end_i(frame_end_i),
    .track_enable_i(track_enable_i),
    .centroid_o(centroid),
    .centroid_valid_o(centroid_valid_o)
  );

  assign centroid_o = centroid;

  // ==========================================================
  // drawing
  // ==========================================================

  // overlay uses the held centroid, so a new result shows from
  // the next drawn pixel on
  overlay_mux overlay (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .masked_i(masked_pixel),
    .centroid_i(centroid),
    .mode_i(mode_i),
    .pixel_o(pixel_o),
    .pixel_valid_o(pixel_valid_o)
  );

endmodule

`default_nettype wire

/* tests/chroma_tracker_props.sv */
`timescale 1ns/10ps
`default_nettype none

module chroma_tracker_props (
  input wire clk_pixel,
  input wire recent_reset,
  input wire beat_valid_i,
  input wire out_valid_i,
  input wire centroid_valid_i
);

  // ============================================================
  // reset and strobe rules
  // ============================================================

  // output register is cleared by reset
  reset_quiet: assert property (@(posedge clk_pixel) recent_reset |=> !out_valid_i)
    else $error("pixel_valid_o high during reset");

  centroid_strobe_single: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    centroid_valid_i |=> !centroid_valid_i)
    else $error("centroid_valid_o high for two cycles in a row");

  // classifier plus overlay, two registers
  pixel_latency: assert property (@(posedge clk_pixel) disable iff (recent_reset)
    out_valid_i == $past(beat_valid_i, 2))
    else $error("pixel_valid_o does not follow pixel_i valid by 2 cycles");

endmodule

bind chroma_tracker chroma_tracker_props props_check (
  .clk_pixel(clk_pixel),
  .recent_reset(recent_reset),
  .beat_valid_i(pixel_i.valid),
  .out_valid_i(pixel_valid_o),
  .centroid_valid_i(centroid_valid_o)
);

`default_nettype wire

/* tests/chroma_tracker_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module chroma_tracker_tb;
  import tracker_pkg::*;

  localparam int CLK_HALF = 20;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 16;
  // quotient width for coordinates up to 1280
  localparam int QUOT_BITS = 11;
  // all tests together need well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 20000;

  logic clk_pixel;
  logic recent_reset;
  pixel_in_t pixel_i;
  logic frame_end_i;
  thresholds_t thresholds_i;
  display_mode_t mode_i;
  logic track_enable_i;
  rgb888_t pixel_o;
  logic pixel_valid_o;
  centroid_t centroid_o;
  logic centroid_valid_o;

  int seed;
  int errors;
  int checks;
  int test_errors;
  int cycle_count;
  // expected output of the two beats still in the pipeline
  logic [1:0] pipe_valid;
  rgb888_t pipe_color [2];
  int exp_cx;
  int exp_cy;

  chroma_tracker #(
    .SCREEN_WIDTH(SCREEN_WIDTH),
    .SCREEN_HEIGHT(SCREEN_HEIGHT)
  ) UUT (
    .clk_pixel(clk_pixel),
    .recent_reset(recent_reset),
    .pixel_i(pixel_i),
    .frame_end_i(frame_end_i),
    .thresholds_i(thresholds_i),
    .mode_i(mode_i),
    .track_enable_i(track_enable_i),
    .pixel_o(pixel_o),
    .pixel_valid_o(pixel_valid_o),
    .centroid_o(centroid_o),
    .centroid_valid_o(centroid_valid_o)
  );

  initial clk_pixel = 1'b0;
  always #CLK_HALF clk_pixel = ~clk_pixel;

  always @(posedge clk_pixel) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // ============================================================
  // reference model and helpers
  // ============================================================

  // zero padded widening of each channel
  function automatic rgb888_t expand(input rgb565_t c);
    rgb888_t e;
    e.r = 8'(int'(c.r) * 8);
    e.g = 8'(int'(c.g) * 4);
    e.b = 8'(int'(c.b) * 8);
    return e;
  endfunction

  // green at or below its bound and red and blue inside [lower, F0]
  function automatic logic is_player(input rgb565_t c, input thresholds_t th);
    int r8;
    int g8;
    int b8;
    r8 = int'(c.r) * 8;
    g8 = int'(c.g) * 4;
    b8 = int'(c.b) * 8;
    return (g8 <= int'(th.green_upper) * 16) &&
           (r8 >= int'(th.red_lower) * 16) && (r8 <= 240) &&
           (b8 >= int'(th.blue_lower) * 16) && (b8 <= 240);
  endfunction

  function automatic pixel_in_t make_beat(input logic v, input int h, input int y,
                                          input rgb565_t c);
    pixel_in_t b;
    b.valid = v;
    b.hcount = HCOUNT_BITS'(h);
    b.vcount = VCOUNT_BITS'(y);
    b.color = c;
    return b;
  endfunction

  function automatic rgb565_t rand_color();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  // random coordinate below limit that never equals avoid
  function automatic int rand_coord(input int limit, input int avoid);
    int c;
    c = {$random(seed)} % limit;
    if (c == avoid) begin
      c = (c + 1) % limit;
    end
    return c;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic step();
    @(posedge clk_pixel);
    #DRIVE_DELAY;
  endtask

  // checks the beat from two calls back and drives a new one
  task automatic cycle_beat(input pixel_in_t beat, input rgb888_t expected);
    check_value("pixel_valid_o", pixel_valid_o, pipe_valid[1]);
    if (pipe_valid[1]) begin
      check_value("pixel_o", pixel_o, pipe_color[1]);
    end
    pipe_valid[1] = pipe_valid[0];
    pipe_color[1] = pipe_color[0];
    pipe_valid[0] = beat.valid;
    pipe_color[0] = expected;
    pixel_i = beat;
    step();
  endtask

  task automatic idle_cycle();
    cycle_beat(make_beat(1'b0, 0, 0, '0), '0);
  endtask

  // settle the accumulators before one frame end strobe
  task automatic end_frame();
    repeat (4) idle_cycle();
    frame_end_i = 1'b1;
    idle_cycle();
    frame_end_i = 1'b0;
  endtask

  task automatic finish_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_errors);
    test_errors = errors;
  endtask

  // ============================================================
  // directed tests
  // ============================================================

  task automatic test_reset();
    repeat (RESET_CYCLES) begin
      step();
      check_value("pixel_valid_o in reset", pixel_valid_o, 0);
      check_value("centroid_valid_o in reset", centroid_valid_o, 0);
      check_value("centroid_o in reset", centroid_o, 0);
    end
    recent_reset = 1'b0;
    step();
    check_value("pixel_valid_o after reset", pixel_valid_o, 0);
    check_value("centroid_valid_o after reset", centroid_valid_o, 0);
    check_value("centroid_o after reset", centroid_o, 0);
    finish_test("reset");
  endtask

  task automatic test_camera();
    rgb565_t c;
    logic [31:0] r;
    mode_i = DISP_CAMERA;
    repeat (48) begin
      c = rand_color();
      r = $random(seed);
      // about one beat in four is a gap
      cycle_beat(make_beat(r[31:30] != 2'b00, r[10:0] % SCREEN_WIDTH,
                           r[25:16] % SCREEN_HEIGHT, c), expand(c));
    end
    repeat (2) idle_cycle();
    finish_test("camera");
  endtask

  task automatic test_mask();
    rgb565_t c;
    logic [31:0] r;
    mode_i = DISP_MASK;
    for (int g = 0; g < 8; g++) begin
      r = $random(seed);
      thresholds_i = r[11:0];
      repeat (16) begin
        c = rand_color();
        cycle_beat(make_beat(1'b1, g * 16, g, c),
                   is_player(c, thresholds_i) ? 24'hFFFFFF : 24'h000000);
      end
      repeat (2) idle_cycle();
    end
    finish_test("mask");
  endtask

  task automatic test_tint();
    rgb565_t c;
    mode_i = DISP_TINT;
    thresholds_i = '{green_upper: 4'h3, red_lower: 4'h8, blue_lower: 4'h8};
    for (int i = 0; i < 16; i++) begin
      c = rand_color();
      // every other beat lands inside the player window
      if (i % 2 == 0) begin
        c.g = {3'b000, c.g[2:0]};
        c.r = {2'b10, c.r[2:0]};
        c.b = {2'b10, c.b[2:0]};
      end
      cycle_beat(make_beat(1'b1, i, i, c),
                 is_player(c, thresholds_i) ? MASK_TINT_COLOR : expand(c));
    end
    repeat (2) idle_cycle();
    mode_i = DISP_CAMERA;
    finish_test("tint");
  endtask

  task automatic test_centroid();
    int pts_x [6] = '{100, 103, 110, 97, 120, 101};
    int pts_y [6] = '{50, 52, 49, 60, 55, 58};
    int sum_x;
    int sum_y;
    int waited;
    rgb565_t player;
    rgb565_t other;
    sum_x = 0;
    sum_y = 0;
    player = '{r: 5'h14, g: 6'h04, b: 5'h14};
    thresholds_i = '{green_upper: 4'h3, red_lower: 4'h8, blue_lower: 4'h8};
    mode_i = DISP_CAMERA;
    track_enable_i = 1'b1;
    for (int i = 0; i < 6; i++) begin
      sum_x += pts_x[i];
      sum_y += pts_y[i];
      cycle_beat(make_beat(1'b1, pts_x[i], pts_y[i], player), expand(player));
      // green far above the bound keeps it out of the mask
      other = rand_color();
      other.g = {2'b11, other.g[3:0]};
      cycle_beat(make_beat(1'b1, rand_coord(SCREEN_WIDTH, -1),
                           rand_coord(SCREEN_HEIGHT, -1), other), expand(other));
    end
    // player colour without valid must not count
    cycle_beat(make_beat(1'b0, 1000, 700, player), '0);
    exp_cx = sum_x / 6;
    exp_cy = sum_y / 6;
    end_frame();
    waited = 1;
    while (!centroid_valid_o && waited < QUOT_BITS + 20) begin
      idle_cycle();
      waited++;
    end
    if (!centroid_valid_o) begin
      errors++;
      $display("centroid strobe never arrived after frame end");
    end else begin
      check_value("centroid strobe latency", waited, QUOT_BITS + 2);
      check_value("centroid x", centroid_o.x, exp_cx);
      check_value("centroid y", centroid_o.y, exp_cy);
      check_value("centroid locked", centroid_o.locked, 1);
      idle_cycle();
      check_value("centroid strobe width", centroid_valid_o, 0);
    end
    track_enable_i = 1'b0;
    finish_test("centroid");
  endtask

  task automatic test_crosshair();
    rgb565_t c;
    mode_i = DISP_CROSSHAIR;
    for (int i = 0; i < 8; i++) begin
      c = rand_color();
      cycle_beat(make_beat(1'b1, rand_coord(SCREEN_WIDTH, exp_cx), exp_cy, c),
                 CROSSHAIR_COLOR);
      c = rand_color();
      cycle_beat(make_beat(1'b1, exp_cx, rand_coord(SCREEN_HEIGHT, exp_cy), c),
                 CROSSHAIR_COLOR);
      c = rand_color();
      cycle_beat(make_beat(1'b1, rand_coord(SCREEN_WIDTH, exp_cx),
                           rand_coord(SCREEN_HEIGHT, exp_cy), c), expand(c));
    end
    c = rand_color();
    cycle_beat(make_beat(1'b1, exp_cx, exp_cy, c), CROSSHAIR_COLOR);
    repeat (2) idle_cycle();
    mode_i = DISP_CAMERA;
    finish_test("crosshair");
  endtask

  // no strobe and an unchanged centroid for a while after frame end
  task automatic watch_quiet(input centroid_t held);
    repeat (QUOT_BITS + 10) begin
      idle_cycle();
      check_value("unexpected centroid strobe", centroid_valid_o, 0);
      check_value("held centroid", centroid_o, held);
    end
  endtask

  task automatic test_no_update();
    centroid_t held;
    rgb565_t c;
    held = '{locked: 1'b1, x: HCOUNT_BITS'(exp_cx), y: VCOUNT_BITS'(exp_cy)};
    // enabled with nothing that qualifies
    track_enable_i = 1'b1;
    repeat (12) begin
      c = rand_color();
      c.g = {2'b11, c.g[3:0]};
      cycle_beat(make_beat(1'b1, rand_coord(SCREEN_WIDTH, -1),
                           rand_coord(SCREEN_HEIGHT, -1), c), expand(c));
    end
    end_frame();
    watch_quiet(held);
    // players present while tracking is off
    track_enable_i = 1'b0;
    c = '{r: 5'h14, g: 6'h04, b: 5'h14};
    repeat (12) begin
      cycle_beat(make_beat(1'b1, rand_coord(SCREEN_WIDTH, -1),
                           rand_coord(SCREEN_HEIGHT, -1), c), expand(c));
    end
    end_frame();
    watch_quiet(held);
    finish_test("empty and disabled frames");
  endtask

  initial begin
    seed = 32'h741d;
    errors = 0;
    checks = 0;
    test_errors = 0;
    cycle_count = 0;
    pipe_valid = 2'b00;
    pipe_color[0] = '0;
    pipe_color[1] = '0;
    recent_reset = 1'b1;
    pixel_i = '0;
    frame_end_i = 1'b0;
    thresholds_i = '0;
    mode_i = DISP_CAMERA;
    track_enable_i = 1'b0;
    test_reset();
    test_camera();
    test_mask();
    test_tint();
    test_centroid();
    test_crosshair();
    test_no_update();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* chroma_tracker.f */
rtl/tracker_pkg.sv
rtl/mask_classifier.sv
rtl/serial_divider.sv
rtl/centroid_tracker.sv
rtl/overlay_mux.sv
rtl/chroma_tracker.sv
tests/chroma_tracker_props.sv
tests/chroma_tracker_tb.sv
